// ==== common/cpuPkg.sv ====
`default_nettype none

package cpuPkg;

   // Machine word
   localparam int dataWidth = 32;
   typedef logic [dataWidth-1:0] word_t;

   // Register addressing, r31 takes the JAL link
   localparam int regAddrWidth = 5;
   typedef logic [regAddrWidth-1:0] regAddr_t;
   localparam regAddr_t linkReg = 5'd31;

   // First fetch address out of reset
   localparam word_t resetPc = 32'h0000_0000;

   typedef logic [5:0] opcode_t;
   typedef logic [5:0] funct_t;

   // Primary opcodes
   localparam opcode_t opSpecial = 6'h00;
   localparam opcode_t opJ       = 6'h02;
   localparam opcode_t opJal     = 6'h03;
   localparam opcode_t opBeq     = 6'h04;
   localparam opcode_t opBne     = 6'h05;
   localparam opcode_t opAddiu   = 6'h09;
   localparam opcode_t opSlti    = 6'h0a;
   localparam opcode_t opSltiu   = 6'h0b;
   localparam opcode_t opAndi    = 6'h0c;
   localparam opcode_t opOri     = 6'h0d;
   localparam opcode_t opXori    = 6'h0e;
   localparam opcode_t opLui     = 6'h0f;
   localparam opcode_t opLb      = 6'h20;
   localparam opcode_t opLh      = 6'h21;
   localparam opcode_t opLw      = 6'h23;
   localparam opcode_t opLbu     = 6'h24;
   localparam opcode_t opLhu     = 6'h25;
   localparam opcode_t opSb      = 6'h28;
   localparam opcode_t opSh      = 6'h29;
   localparam opcode_t opSw      = 6'h2b;

   // SPECIAL function codes
   localparam funct_t fnSll  = 6'h00;
   localparam funct_t fnSrl  = 6'h02;
   localparam funct_t fnSra  = 6'h03;
   localparam funct_t fnJr   = 6'h08;
   localparam funct_t fnJalr = 6'h09;
   localparam funct_t fnAddu = 6'h21;
   localparam funct_t fnSubu = 6'h23;
   localparam funct_t fnAnd  = 6'h24;
   localparam funct_t fnOr   = 6'h25;
   localparam funct_t fnXor  = 6'h26;
   localparam funct_t fnNor  = 6'h27;
   localparam funct_t fnSlt  = 6'h2a;
   localparam funct_t fnSltu = 6'h2b;

   typedef enum logic [3:0] {
      aluAdd, aluSub, aluAnd, aluOr, aluXor, aluNor,
      aluSlt, aluSltu, aluSll, aluSrl, aluSra, aluLui
   } aluOp_t;

   typedef enum logic [1:0] {sizeByte, sizeHalf, sizeWord} memSize_t;

   // One enable per byte lane, bit 0 is the low byte
   typedef logic [3:0] byteEn_t;

   // Three views of the same instruction word
   typedef struct packed {
      opcode_t    opcode;
      regAddr_t   rs;
      regAddr_t   rt;
      regAddr_t   rd;
      logic [4:0] shamt;
      funct_t     funct;
   } rFormat_t;

   typedef struct packed {
      opcode_t     opcode;
      regAddr_t    rs;
      regAddr_t    rt;
      logic [15:0] imm;
   } iFormat_t;

   typedef struct packed {
      opcode_t     opcode;
      logic [25:0] target;
   } jFormat_t;

   typedef union packed {
      rFormat_t r;
      iFormat_t i;
      jFormat_t j;
   } instr_t;

   // Decode control bundle, all zero is a bubble
   typedef struct packed {
      logic     regWrite;
      logic     memToReg;
      logic     memWrite;
      logic     memRead;
      logic     aluSrc;
      logic     regDst;
      logic     shift;
      logic     link;
      logic     jump;
      logic     jumpReg;
      logic     branch;
      logic     branchNe;
      aluOp_t   aluOp;
      memSize_t memSize;
      logic     loadSigned;
   } ctrl_t;

   // Decode to execute register
   typedef struct packed {
      ctrl_t       ctrl;
      word_t       pc;
      word_t       rsVal;
      word_t       rtVal;
      regAddr_t    rsAddr;
      regAddr_t    rtAddr;
      regAddr_t    destAddr;
      word_t       imm;
      logic [4:0]  shamt;
      logic [25:0] target;
   } exStage_t;

   // Execute to memory register
   typedef struct packed {
      logic       regWrite;
      logic       memToReg;
      logic       link;
      memSize_t   memSize;
      logic       loadSigned;
      regAddr_t   destAddr;
      word_t      aluResult;
      word_t      pc;
      logic [1:0] byteOffset;
   } memStage_t;

endpackage

`default_nettype wire

// ==== hdl/instrDecoder.sv ====
`timescale 1ns/1ps
`default_nettype none

module instrDecoder (
   input  wire cpuPkg::instr_t instr,
   output cpuPkg::ctrl_t       ctrl,
   output cpuPkg::word_t       imm
);

   logic zeroExt;

   always_comb begin
      // Unknown encodings fall out as a bubble
      ctrl = '0;
      case (instr.r.opcode)
         cpuPkg::opSpecial: begin
            ctrl.regWrite = 1'b1;
            ctrl.regDst   = 1'b1;
            case (instr.r.funct)
               cpuPkg::fnSll:  ctrl.aluOp = cpuPkg::aluSll;
               cpuPkg::fnSrl:  ctrl.aluOp = cpuPkg::aluSrl;
               cpuPkg::fnSra:  ctrl.aluOp = cpuPkg::aluSra;
               cpuPkg::fnAddu: ctrl.aluOp = cpuPkg::aluAdd;
               cpuPkg::fnSubu: ctrl.aluOp = cpuPkg::aluSub;
               cpuPkg::fnAnd:  ctrl.aluOp = cpuPkg::aluAnd;
               cpuPkg::fnOr:   ctrl.aluOp = cpuPkg::aluOr;
               cpuPkg::fnXor:  ctrl.aluOp = cpuPkg::aluXor;
               cpuPkg::fnNor:  ctrl.aluOp = cpuPkg::aluNor;
               cpuPkg::fnSlt:  ctrl.aluOp = cpuPkg::aluSlt;
               cpuPkg::fnSltu: ctrl.aluOp = cpuPkg::aluSltu;
               cpuPkg::fnJr: begin
                  ctrl.regWrite = 1'b0;
                  ctrl.jumpReg  = 1'b1;
               end
               // JALR links into rd
               cpuPkg::fnJalr: begin
                  ctrl.jumpReg = 1'b1;
                  ctrl.link    = 1'b1;
               end
               default: begin
                  ctrl.regWrite = 1'b0;
                  ctrl.regDst   = 1'b0;
               end
            endcase
            // Shift amount comes from shamt, not rs
            ctrl.shift = ctrl.aluOp inside {cpuPkg::aluSll, cpuPkg::aluSrl, cpuPkg::aluSra};
         end
         cpuPkg::opAddiu, cpuPkg::opSlti, cpuPkg::opSltiu, cpuPkg::opAndi,
         cpuPkg::opOri, cpuPkg::opXori, cpuPkg::opLui: begin
            ctrl.regWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            case (instr.i.opcode)
               cpuPkg::opSlti:  ctrl.aluOp = cpuPkg::aluSlt;
               cpuPkg::opSltiu: ctrl.aluOp = cpuPkg::aluSltu;
               cpuPkg::opAndi:  ctrl.aluOp = cpuPkg::aluAnd;
               cpuPkg::opOri:   ctrl.aluOp = cpuPkg::aluOr;
               cpuPkg::opXori:  ctrl.aluOp = cpuPkg::aluXor;
               cpuPkg::opLui:   ctrl.aluOp = cpuPkg::aluLui;
               default:         ctrl.aluOp = cpuPkg::aluAdd;
            endcase
         end
         // Loads, address is rs plus offset
         cpuPkg::opLb, cpuPkg::opLh, cpuPkg::opLw, cpuPkg::opLbu, cpuPkg::opLhu: begin
            ctrl.regWrite = 1'b1;
            ctrl.memToReg = 1'b1;
            ctrl.memRead  = 1'b1;
            ctrl.aluSrc   = 1'b1;
            ctrl.loadSigned = instr.i.opcode inside {cpuPkg::opLb, cpuPkg::opLh};
            if (instr.i.opcode inside {cpuPkg::opLb, cpuPkg::opLbu}) begin
               ctrl.memSize = cpuPkg::sizeByte;
            end else if (instr.i.opcode inside {cpuPkg::opLh, cpuPkg::opLhu}) begin
               ctrl.memSize = cpuPkg::sizeHalf;
            end else begin
               ctrl.memSize = cpuPkg::sizeWord;
            end
         end
         cpuPkg::opSb, cpuPkg::opSh, cpuPkg::opSw: begin
            ctrl.memWrite = 1'b1;
            ctrl.aluSrc   = 1'b1;
            case (instr.i.opcode)
               cpuPkg::opSb: ctrl.memSize = cpuPkg::sizeByte;
               cpuPkg::opSh: ctrl.memSize = cpuPkg::sizeHalf;
               default:      ctrl.memSize = cpuPkg::sizeWord;
            endcase
         end
         cpuPkg::opBeq: ctrl.branch = 1'b1;
         cpuPkg::opBne: begin
            ctrl.branch   = 1'b1;
            ctrl.branchNe = 1'b1;
         end
         cpuPkg::opJ: ctrl.jump = 1'b1;
         // JAL, destination forced to r31 in the core
         cpuPkg::opJal: begin
            ctrl.jump     = 1'b1;
            ctrl.link     = 1'b1;
            ctrl.regWrite = 1'b1;
         end
         default: ctrl = '0;
      endcase
   end

   // Logical immediates are zero extended, the rest sign extended
   assign zeroExt = instr.i.opcode inside {cpuPkg::opAndi, cpuPkg::opOri, cpuPkg::opXori};
   assign imm     = zeroExt ? {16'h0000, instr.i.imm} : {{16{instr.i.imm[15]}}, instr.i.imm};

endmodule

`default_nettype wire

// ==== hdl/programCounter.sv ====
`timescale 1ns/1ps
`default_nettype none

module programCounter (
   input  wire                clk,
   input  wire                reset,
   input  wire                stall,
   input  wire                redirect,
   input  wire cpuPkg::word_t target,
   output cpuPkg::word_t      pc,
   output cpuPkg::word_t      nextPc
);

   // pc is the address of the word now on instr
   always_ff @(posedge clk) begin
      if (reset) begin
         pc <= cpuPkg::resetPc;
      end else if (!stall) begin
         pc <= nextPc;
      end
   end

   // Fetch address for the synchronous instruction memory
   always_comb begin
      if (stall || reset) begin
         // Re-present the current word so it is still there next cycle
         nextPc = pc;
      end else if (redirect) begin
         nextPc = target;
      end else begin
         nextPc = pc + 32'd4;
      end
   end

   // Misaligned jump targets would walk off the word grid
   pcAligned : assert property (@(posedge clk) disable iff (reset) pc[1:0] == 2'b00)
      else $error("pc not word aligned: %h", pc);

endmodule

`default_nettype wire

// ==== hdl/regFile.sv ====
`timescale 1ns/1ps
`default_nettype none

module regFile (
   input  wire                   clk,
   input  wire                   we,
   input  wire cpuPkg::regAddr_t readAddrA,
   input  wire cpuPkg::regAddr_t readAddrB,
   input  wire cpuPkg::regAddr_t writeAddr,
   input  wire cpuPkg::word_t    writeData,
   output cpuPkg::word_t         readDataA,
   output cpuPkg::word_t         readDataB
);

   // No storage behind r0
   cpuPkg::word_t regs [1:2**cpuPkg::regAddrWidth-1];

   always_ff @(posedge clk) begin
      if (we && writeAddr != '0) begin
         regs[writeAddr] <= writeData;
      end
   end

   // Asynchronous reads
   assign readDataA = (readAddrA == '0) ? '0 : regs[readAddrA];
   assign readDataB = (readAddrB == '0) ? '0 : regs[readAddrB];

endmodule

`default_nettype wire

// ==== hdl/alu.sv ====
`timescale 1ns/1ps
`default_nettype none

module alu (
   input  wire cpuPkg::word_t  a,
   input  wire cpuPkg::word_t  b,
   input  wire cpuPkg::aluOp_t op,
   output cpuPkg::word_t       result
);

   logic [4:0] shamt;

   // Shifts take their amount from a, shifted value is b
   assign shamt = a[4:0];

   always_comb begin
      case (op)
         cpuPkg::aluAdd:  result = a + b;
         cpuPkg::aluSub:  result = a - b;
         cpuPkg::aluAnd:  result = a & b;
         cpuPkg::aluOr:   result = a | b;
         cpuPkg::aluXor:  result = a ^ b;
         cpuPkg::aluNor:  result = ~(a | b);
         // Compares give 0 or 1
         cpuPkg::aluSlt:  result = cpuPkg::word_t'($signed(a) < $signed(b));
         cpuPkg::aluSltu: result = cpuPkg::word_t'(a < b);
         cpuPkg::aluSll:  result = b << shamt;
         cpuPkg::aluSrl:  result = b >> shamt;
         cpuPkg::aluSra:  result = cpuPkg::word_t'($signed(b) >>> shamt);
         // Immediate into the upper half
         cpuPkg::aluLui:  result = {b[15:0], 16'h0000};
         default:         result = '0;
      endcase
   end

endmodule

`default_nettype wire

// ==== hdl/loadStoreMask.sv ====
`timescale 1ns/1ps
`default_nettype none

module loadStoreMask (
   input  wire cpuPkg::memSize_t storeSize,
   input  wire cpuPkg::memSize_t loadSize,
   input  wire [1:0]             storeOffset,
   input  wire [1:0]             loadOffset,
   input  wire                   storeEnable,
   input  wire                   loadSigned,
   input  wire cpuPkg::word_t    storeIn,
   input  wire cpuPkg::word_t    loadIn,
   output cpuPkg::word_t         storeOut,
   output cpuPkg::word_t         loadOut,
   output cpuPkg::byteEn_t       byteWe
);

   cpuPkg::byteEn_t laneMask;
   cpuPkg::word_t   loadShifted;

   // Store side, data copied into every lane, enables pick the lanes
   always_comb begin
      case (storeSize)
         cpuPkg::sizeByte: begin
            storeOut = {4{storeIn[7:0]}};
            laneMask = 4'b0001 << storeOffset;
         end
         cpuPkg::sizeHalf: begin
            storeOut = {2{storeIn[15:0]}};
            laneMask = storeOffset[1] ? 4'b1100 : 4'b0011;
         end
         default: begin
            storeOut = storeIn;
            laneMask = 4'b1111;
         end
      endcase
   end

   // No lanes unless a store is in execute
   assign byteWe = storeEnable ? laneMask : '0;

   // Load side, addressed lane moved down to bit 0
   assign loadShifted = loadIn >> {loadOffset, 3'b000};

   always_comb begin
      case (loadSize)
         cpuPkg::sizeByte: begin
            loadOut = {{24{loadSigned & loadShifted[7]}}, loadShifted[7:0]};
         end
         cpuPkg::sizeHalf: begin
            loadOut = {{16{loadSigned & loadShifted[15]}}, loadShifted[15:0]};
         end
         default: loadOut = loadIn;
      endcase
   end

   // Alignment of store accesses, checked once inputs settle
   always_comb begin
      if (storeEnable) begin
         halfAligned : assert final (storeSize != cpuPkg::sizeHalf || !storeOffset[0])
            else $error("half store at odd offset %0d", storeOffset);
         wordAligned : assert final (storeSize != cpuPkg::sizeWord || storeOffset == 2'b00)
            else $error("word store at offset %0d", storeOffset);
      end
   end

endmodule

`default_nettype wire

// ==== pipeline/cpuCore.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCore (
   input  wire                clk,
   input  wire                reset,
   input  wire                stall,
   input  wire cpuPkg::word_t instr,
   input  wire cpuPkg::word_t loadData,
   output cpuPkg::word_t      instrAddr,
   output cpuPkg::word_t      dataAddr,
   output cpuPkg::word_t      storeData,
   output cpuPkg::byteEn_t    byteWe,
   output logic               dataRe
);

   // Fetch and decode
   cpuPkg::instr_t    decInstr;
   cpuPkg::ctrl_t     decCtrl;
   cpuPkg::word_t     decImm;
   cpuPkg::word_t     pc;
   cpuPkg::word_t     rfDataA;
   cpuPkg::word_t     rfDataB;
   cpuPkg::exStage_t  exNext;

   // Execute
   cpuPkg::exStage_t  ex;
   cpuPkg::word_t     rsFwd;
   cpuPkg::word_t     rtFwd;
   cpuPkg::word_t     aluA;
   cpuPkg::word_t     aluB;
   cpuPkg::word_t     aluResult;
   cpuPkg::word_t     exPcPlus4;
   cpuPkg::word_t     redirectTarget;
   logic              branchTaken;
   logic              redirect;
   cpuPkg::memStage_t memNext;

   // Memory and write-back
   cpuPkg::memStage_t mem;
   cpuPkg::word_t     loadOut;
   cpuPkg::word_t     wbData;
   logic              wbValid;

   assign decInstr = instr;

   instrDecoder i_decoder (
      .instr (decInstr),
      .ctrl  (decCtrl),
      .imm   (decImm)
   );

   // Fetch address goes straight out to instruction memory
   programCounter i_pc (
      .clk      (clk),
      .reset    (reset),
      .stall    (stall),
      .redirect (redirect),
      .target   (redirectTarget),
      .pc       (pc),
      .nextPc   (instrAddr)
   );

   regFile i_regFile (
      .clk       (clk),
      .we        (mem.regWrite && !stall),
      .readAddrA (decInstr.r.rs),
      .readAddrB (decInstr.r.rt),
      .writeAddr (mem.destAddr),
      .writeData (wbData),
      .readDataA (rfDataA),
      .readDataB (rfDataB)
   );

   // Write-back bypasses the same-cycle register write in decode
   always_comb begin
      exNext.ctrl   = decCtrl;
      exNext.pc     = pc;
      exNext.rsAddr = decInstr.r.rs;
      exNext.rtAddr = decInstr.r.rt;
      exNext.rsVal  = (wbValid && mem.destAddr == decInstr.r.rs) ? wbData : rfDataA;
      exNext.rtVal  = (wbValid && mem.destAddr == decInstr.r.rt) ? wbData : rfDataB;
      // JAL to r31, R-type to rd, the rest to rt
      if (decCtrl.link && decCtrl.jump) begin
         exNext.destAddr = cpuPkg::linkReg;
      end else if (decCtrl.regDst) begin
         exNext.destAddr = decInstr.r.rd;
      end else begin
         exNext.destAddr = decInstr.r.rt;
      end
      exNext.imm    = decImm;
      exNext.shamt  = decInstr.r.shamt;
      exNext.target = decInstr.j.target;
   end

   // A cleared control bundle is a bubble
   always_ff @(posedge clk) begin
      if (reset) begin
         ex.ctrl <= '0;
      end else if (!stall) begin
         ex <= exNext;
      end
   end

   // Operands from the memory stage win over the registered values
   assign rsFwd = (wbValid && mem.destAddr == ex.rsAddr) ? wbData : ex.rsVal;
   assign rtFwd = (wbValid && mem.destAddr == ex.rtAddr) ? wbData : ex.rtVal;

   assign aluA = ex.ctrl.shift ? cpuPkg::word_t'(ex.shamt) : rsFwd;
   assign aluB = ex.ctrl.aluSrc ? ex.imm : rtFwd;

   alu i_alu (
      .a      (aluA),
      .b      (aluB),
      .op     (ex.ctrl.aluOp),
      .result (aluResult)
   );

   // BNE inverts the sense of the forwarded compare
   assign branchTaken = ex.ctrl.branch && ((rsFwd == rtFwd) != ex.ctrl.branchNe);
   assign redirect    = branchTaken || ex.ctrl.jump || ex.ctrl.jumpReg;

   // Targets relative to the delay slot
   assign exPcPlus4 = ex.pc + 32'd4;

   always_comb begin
      if (ex.ctrl.jumpReg) begin
         redirectTarget = rsFwd;
      end else if (ex.ctrl.jump) begin
         redirectTarget = {exPcPlus4[31:28], ex.target, 2'b00};
      end else begin
         redirectTarget = exPcPlus4 + {ex.imm[29:0], 2'b00};
      end
   end

   loadStoreMask i_lsMask (
      .storeSize   (ex.ctrl.memSize),
      .loadSize    (mem.memSize),
      .storeOffset (aluResult[1:0]),
      .loadOffset  (mem.byteOffset),
      .storeEnable (ex.ctrl.memWrite),
      .loadSigned  (mem.loadSigned),
      .storeIn     (rtFwd),
      .loadIn      (loadData),
      .storeOut    (storeData),
      .loadOut     (loadOut),
      .byteWe      (byteWe)
   );

   // Data memory request straight from execute
   assign dataAddr = aluResult;
   assign dataRe   = ex.ctrl.memRead;

   always_comb begin
      memNext.regWrite   = ex.ctrl.regWrite;
      memNext.memToReg   = ex.ctrl.memToReg;
      memNext.link       = ex.ctrl.link;
      memNext.memSize    = ex.ctrl.memSize;
      memNext.loadSigned = ex.ctrl.loadSigned;
      memNext.destAddr   = ex.destAddr;
      memNext.aluResult  = aluResult;
      memNext.pc         = ex.pc;
      memNext.byteOffset = aluResult[1:0];
   end

   always_ff @(posedge clk) begin
      if (reset) begin
         mem.regWrite <= 1'b0;
         mem.memToReg <= 1'b0;
         mem.link     <= 1'b0;
      end else if (!stall) begin
         mem <= memNext;
      end
   end

   // Links return past the delay slot
   always_comb begin
      if (mem.link) begin
         wbData = mem.pc + 32'd8;
      end else if (mem.memToReg) begin
         wbData = loadOut;
      end else begin
         wbData = mem.aluResult;
      end
   end

   // r0 never forwards
   assign wbValid = mem.regWrite && (mem.destAddr != '0);

   // Lane enables only from a store in execute, as many lanes as the access has bytes
   noStrayWrite : assert property (@(posedge clk) disable iff (reset)
      $countones(byteWe) == (!ex.ctrl.memWrite ? 0 :
                             ex.ctrl.memSize == cpuPkg::sizeByte ? 1 :
                             ex.ctrl.memSize == cpuPkg::sizeHalf ? 2 : 4))
      else $error("byteWe %b does not fit the access in execute", byteWe);

   // Register zero reads as zero even while the memory stage writes it
   zeroRead : assert property (@(posedge clk) disable iff (reset)
      (decInstr.r.rs != '0 || exNext.rsVal == '0) &&
      (decInstr.r.rt != '0 || exNext.rtVal == '0))
      else $error("register zero read as nonzero in decode");

endmodule

`default_nettype wire

// ==== tb/cpuCoreTb.sv ====
`timescale 1ns/1ps
`default_nettype none

module cpuCoreTb;

   localparam int memWords  = 64;
   localparam int maxStores = 32;
   localparam int clkHalf   = 20;

   logic            clk;
   logic            reset;
   logic            stall;
   cpuPkg::word_t   instr;
   cpuPkg::word_t   loadData;
   cpuPkg::word_t   instrAddr;
   cpuPkg::word_t   dataAddr;
   cpuPkg::word_t   storeData;
   cpuPkg::byteEn_t byteWe;
   logic            dataRe;

   // Word-indexed instruction and data memory images
   cpuPkg::word_t imem [memWords];
   cpuPkg::word_t dmem [memWords];

   // Expected stores in program order
   cpuPkg::word_t   expAddr [maxStores];
   cpuPkg::word_t   expData [maxStores];
   cpuPkg::byteEn_t expBe   [maxStores];
   logic [63:0]     expName [maxStores];
   int              numStores;
   int              progWords;
   int              storeIdx;
   logic            loaded = 1'b0;
   integer          seed;

   // Bus requests sampled at the falling edge where they are stable
   cpuPkg::word_t   reqFetch;
   cpuPkg::word_t   reqAddr;
   cpuPkg::word_t   reqData;
   cpuPkg::byteEn_t reqWe;
   logic            reqRe;
   logic            reqStall;
   logic            reqReset;

   cpuCore i_dut (
      .clk       (clk),
      .reset     (reset),
      .stall     (stall),
      .instr     (instr),
      .loadData  (loadData),
      .instrAddr (instrAddr),
      .dataAddr  (dataAddr),
      .storeData (storeData),
      .byteWe    (byteWe),
      .dataRe    (dataRe)
   );

   always #clkHalf clk = ~clk;

   task automatic reportFailure(input string what);
      $display("%s", what);
      $display("test failed");
      $fatal(1, "simulation stopped at the first error");
   endtask

   // One byte of ones per enabled lane
   function automatic cpuPkg::word_t expandLanes(input cpuPkg::byteEn_t be);
      return {{8{be[3]}}, {8{be[2]}}, {8{be[1]}}, {8{be[0]}}};
   endfunction

   task automatic loadStimulus();
      int              fd;
      int              code;
      logic [63:0]     tag;
      logic [63:0]     name;
      logic [1279:0]   rest;
      cpuPkg::word_t   w0;
      cpuPkg::word_t   w1;
      cpuPkg::word_t   w2;
      cpuPkg::word_t   w3;
      cpuPkg::word_t   addr;
      cpuPkg::word_t   value;
      cpuPkg::byteEn_t be;
      for (int i = 0; i < memWords; i++) begin
         // Unknown opcode 3f makes stray fetches decode as bubbles
         imem[i] = {6'h3f, 26'(i * 4)};
         dmem[i] = 32'h5a00_0000 ^ cpuPkg::word_t'(i * 4);
      end
      fd = $fopen("tb/cpuStimulus.txt", "r");
      if (fd == 0) begin
         reportFailure("cannot open tb/cpuStimulus.txt");
      end
      while (!$feof(fd)) begin
         code = $fscanf(fd, "%s", tag);
         if (code == 1) begin
            if (tag == "#") begin
               code = $fgets(rest, fd);
            end else if (tag == "prog") begin
               // Four program words per line from the reset address up
               code = $fscanf(fd, "%s %h %h %h %h", name, w0, w1, w2, w3);
               imem[progWords]     = w0;
               imem[progWords + 1] = w1;
               imem[progWords + 2] = w2;
               imem[progWords + 3] = w3;
               progWords += 4;
            end else if (tag == "data") begin
               code = $fscanf(fd, "%s %h %h", name, addr, value);
               dmem[addr[7:2]] = value;
            end else if (tag == "store") begin
               code = $fscanf(fd, "%s %h %h %h", name, addr, value, be);
               expName[numStores] = name;
               expAddr[numStores] = addr;
               expData[numStores] = value;
               expBe[numStores]   = be;
               numStores++;
            end else begin
               reportFailure($sformatf("unknown line tag %0s in the stimulus file", tag));
            end
         end
      end
      $fclose(fd);
   endtask

   // Compare one committed store with the next list entry
   task automatic checkStore(input cpuPkg::word_t addr, input cpuPkg::word_t data,
                             input cpuPkg::byteEn_t be);
      cpuPkg::word_t masked;
      masked = data & expandLanes(be);
      assert (storeIdx < numStores)
         else reportFailure($sformatf("unexpected store to %h after the last one", addr));
      assert (be == expBe[storeIdx])
         else reportFailure($sformatf("mismatch %0s store %0d byteWe: expected %b actual %b",
                                      expName[storeIdx], storeIdx, expBe[storeIdx], be));
      assert (addr == expAddr[storeIdx])
         else reportFailure($sformatf("mismatch %0s store %0d address: expected %h actual %h",
                                      expName[storeIdx], storeIdx, expAddr[storeIdx], addr));
      assert (masked == expData[storeIdx])
         else reportFailure($sformatf("mismatch %0s store %0d data: expected %h actual %h",
                                      expName[storeIdx], storeIdx, expData[storeIdx], masked));
      storeIdx++;
   endtask

   always @(negedge clk) begin
      reqFetch = instrAddr;
      reqAddr  = dataAddr;
      reqData  = storeData;
      reqWe    = byteWe;
      reqRe    = dataRe;
      reqStall = stall;
      reqReset = reset;
   end

   // Synchronous memories driven a little after the rising edge
   always @(posedge clk) begin
      #2;
      // Instruction memory follows instrAddr every cycle
      instr = imem[reqFetch[7:2]];
      if (!reqStall) begin
         // Read data held while stalled as the load stays in the memory stage
         // Without a read request the word comes back inverted
         loadData = reqRe ? dmem[reqAddr[7:2]] : ~dmem[reqAddr[7:2]];
         if (!reqReset) begin
            assert (!$isunknown({reqWe, reqRe}))
               else reportFailure("byteWe or dataRe is unknown after reset");
            assert (!(reqRe && reqWe != '0))
               else reportFailure("dataRe and byteWe are active in the same cycle");
            if (reqWe != '0) begin
               checkStore(reqAddr, reqData, reqWe);
               for (int k = 0; k < 4; k++) begin
                  if (reqWe[k]) begin
                     dmem[reqAddr[7:2]][8*k +: 8] = reqData[8*k +: 8];
                  end
               end
            end
         end
      end
      // Stall about one cycle in four
      stall = !reqReset && (($random(seed) & 3) == 0);
   end

   initial begin
      wait (loaded);
      // Twenty cycles per word and store and twice that for stall
      repeat (8 + (progWords + numStores) * 20 * 2) @(posedge clk);
      reportFailure($sformatf("timeout with %0d of %0d stores seen", storeIdx, numStores));
   end

   initial begin
      seed      = 32'h5297;
      clk       = 1'b0;
      reset     = 1'b1;
      stall     = 1'b0;
      instr     = '0;
      loadData  = '0;
      reqFetch  = cpuPkg::resetPc;
      reqAddr   = '0;
      reqData   = '0;
      reqWe     = '0;
      reqRe     = 1'b0;
      reqStall  = 1'b0;
      reqReset  = 1'b1;
      storeIdx  = 0;
      numStores = 0;
      progWords = 0;
      loadStimulus();
      loaded = 1'b1;
      repeat (8) @(posedge clk);
      #2;
      reset = 1'b0;
      wait (storeIdx == numStores);
      // Stray stores would show while spinning in the final loop
      repeat (16) @(posedge clk);
      $display("test passed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== tb/cpuStimulus.txt ====
# prog test word0 word1 word2 word3 (from address 0) | data test byteAddr word
# store test byteAddr laneMaskedData byteEnables, in program order
prog alu 3c011234 34218765 2402fff8 00021843
prog fwd 00612023 00042202 ac010000 ac040004
prog alu 0023282b 0023302a 00a63827 38e700f0
prog mem 00073900 ac070008 8c080040 a0080051
prog mem 84090042 940a0040 a4090056 800b0040
prog mem 900c0042 014b6821 01ac6821 ac0d000c
prog ctrl 0c00001c 24100001 24100063 24100063
prog ctrl ac1f0010 16000002 00108040 24100063
prog ctrl 12000002 26100004 26100010 ac100014
prog ctrl 241100a0 0220f809 03e09021 24120063
prog ctrl ac120018 241300b4 02600008 24000005
prog zero ac13001c ac00001c 0800002e 00000000
# word read back by the sub-word loads
data mem 00000040 c3a57f81
# lui and ori, then forwarded subu and srl
store alu 00000000 12348765 f
store fwd 00000004 00edcb78 f
# sltu, slt, nor, xori, sll chain
store alu 00000008 fffff0e0 f
# load-use into sb, lh into sh, lb lbu lhu summed
store mem 00000051 00008100 2
store mem 00000056 c3a50000 c
store mem 0000000c 00007fa7 f
# jal link, bne taken, beq not taken, delay slots
store ctrl 00000010 00000068 f
store ctrl 00000014 00000016 f
# jalr link seen from its delay slot
store ctrl 00000018 0000009c f
# jr delay slot writes r0
store zero 0000001c 00000000 f

// ==== sources.f ====
common/cpuPkg.sv
hdl/instrDecoder.sv
hdl/programCounter.sv
hdl/regFile.sv
hdl/alu.sv
hdl/loadStoreMask.sv
pipeline/cpuCore.sv
tb/cpuCoreTb.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the cpuCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f sources.f --top-module cpuCoreTb -o cpuCoreSim
status=$?
if [ $status -ne 0 ]; then
   echo "verilator build failed with status $status"
   exit 1
fi

./obj_dir/cpuCoreSim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if grep -qx "test passed" sim.log; then
   exit 0
else
   echo "pass line not found in sim.log"
   exit 1
fi
